// File: Bender.yml
package:
  name: arm_core

sources:
  - hdl/arm_pkg.sv
  - hdl/stage_if.sv
  - hdl/fetch_unit.sv
  - hdl/decode_unit.sv
  - hdl/execute_unit.sv
  - hdl/memory_unit.sv
  - hdl/arm_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/arm_core_tb.sv

// File: arm_core.f
hdl/arm_pkg.sv
hdl/stage_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/memory_unit.sv
hdl/arm_core.sv
tests/tb_clock.sv
tests/arm_core_tb.sv

// File: hdl/arm_core.sv
`timescale 1ns/1ps
`default_nettype none

module arm_core #(
   parameter int IMEM_AW = arm_pkg::IMEM_AW,
   parameter int DMEM_AW = arm_pkg::DMEM_AW
) (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic                        host_en_i,
   input  wire logic                        host_we_i,
   input  wire logic [IMEM_AW-1:0]          host_addr_i,
   input  wire logic [arm_pkg::INSTR_W-1:0] host_wdata_i,
   output logic      [arm_pkg::INSTR_W-1:0] host_rdata_o,
   input  wire logic [DMEM_AW-1:0]          dbg_addr_i,
   output logic      [arm_pkg::DATA_W-1:0]  dbg_data_o
);
   import arm_pkg::*;

   logic [INSTR_W-1:0] instr;
   logic               instr_valid;
   logic               wb_we;
   logic [REG_AW-1:0]  wb_addr;
   logic [DATA_W-1:0]  wb_data;

   id_ex_if  id_ex ();
   ex_mem_if ex_mem ();

   fetch_unit #(.IMEM_AW(IMEM_AW)) u_fetch (
      .clk           (clk),
      .reset         (reset),
      .host_en_i     (host_en_i),
      .host_we_i     (host_we_i),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_rdata_o  (host_rdata_o),
      .instr_o       (instr),
      .instr_valid_o (instr_valid)
   );

   decode_unit u_decode (
      .clk           (clk),
      .reset         (reset),
      .instr_i       (instr),
      .instr_valid_i (instr_valid),
      .wb_we_i       (wb_we),
      .wb_addr_i     (wb_addr),
      .wb_data_i     (wb_data),
      .ex_o          (id_ex.src)
   );

   execute_unit u_execute (
      .clk   (clk),
      .reset (reset),
      .id_i  (id_ex.dst),
      .mem_o (ex_mem.src)
   );

   // writeback loops back into the register file
   memory_unit #(.DMEM_AW(DMEM_AW)) u_memory (
      .clk        (clk),
      .reset      (reset),
      .dbg_addr_i (dbg_addr_i),
      .ex_i       (ex_mem.dst),
      .dbg_data_o (dbg_data_o),
      .wb_we_o    (wb_we),
      .wb_addr_o  (wb_addr),
      .wb_data_o  (wb_data)
   );

endmodule

`default_nettype wire

// File: hdl/arm_pkg.sv
`default_nettype none

package arm_pkg;

   // data path and instruction widths
   localparam int DATA_W  = 64;
   localparam int INSTR_W = 32;
   localparam int REG_AW  = 5;

   // default memory depths for the top level parameters
   localparam int IMEM_AW = 6;
   localparam int DMEM_AW = 5;

   // R-type opcodes in instr[31:21]
   localparam logic [10:0] OP_ADD  = 11'b100_0101_1000;
   localparam logic [10:0] OP_SUB  = 11'b110_0101_1000;
   localparam logic [10:0] OP_AND  = 11'b100_0101_0000;
   localparam logic [10:0] OP_ORR  = 11'b101_0101_0000;

   // I-type opcode in instr[31:22]
   localparam logic [9:0]  OP_ADDI = 10'b10_0100_0100;

   // D-type opcodes in instr[31:21]
   localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;
   localparam logic [10:0] OP_STUR = 11'b111_1100_0000;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_ORR = 2'd3
   } alu_op_t;

   // decoded control bits carried down the pipe
   typedef struct packed {
      alu_op_t alu_op;
      logic    use_imm;
      logic    mem_read;
      logic    mem_write;
      logic    reg_write;
      logic    mem_to_reg;
   } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic [arm_pkg::INSTR_W-1:0] instr_i,
   input  wire logic                        instr_valid_i,
   input  wire logic                        wb_we_i,
   input  wire logic [arm_pkg::REG_AW-1:0]  wb_addr_i,
   input  wire logic [arm_pkg::DATA_W-1:0]  wb_data_i,
   id_ex_if.src                             ex_o
);
   import arm_pkg::*;

   localparam logic [REG_AW-1:0] ZERO_REG = '1;

   logic [DATA_W-1:0] rf [2**REG_AW];
   ctrl_t             ctrl_d;
   logic [REG_AW-1:0] rn;
   logic [REG_AW-1:0] rm_sel;
   logic [DATA_W-1:0] rn_data;
   logic [DATA_W-1:0] rm_data;
   logic [DATA_W-1:0] imm_d;
   logic              is_addi;

   assign is_addi = (instr_i[31:22] == OP_ADDI);

   always_comb begin
      // unknown opcodes fall through as bubbles
      ctrl_d = '0;
      if (is_addi) begin
         ctrl_d.use_imm   = 1'b1;
         ctrl_d.reg_write = 1'b1;
      end else begin
         case (instr_i[31:21])
            OP_ADD: ctrl_d.reg_write = 1'b1;
            OP_SUB: begin
               ctrl_d.alu_op    = ALU_SUB;
               ctrl_d.reg_write = 1'b1;
            end
            OP_AND: begin
               ctrl_d.alu_op    = ALU_AND;
               ctrl_d.reg_write = 1'b1;
            end
            OP_ORR: begin
               ctrl_d.alu_op    = ALU_ORR;
               ctrl_d.reg_write = 1'b1;
            end
            OP_LDUR: begin
               ctrl_d.use_imm    = 1'b1;
               ctrl_d.mem_read   = 1'b1;
               ctrl_d.reg_write  = 1'b1;
               ctrl_d.mem_to_reg = 1'b1;
            end
            OP_STUR: begin
               ctrl_d.use_imm   = 1'b1;
               ctrl_d.mem_write = 1'b1;
            end
            default: ;
         endcase
      end
   end

   // STUR reads its store data from Rt
   assign rn     = instr_i[9:5];
   assign rm_sel = (instr_i[31:21] == OP_STUR) ? instr_i[4:0] : instr_i[20:16];

   // X31 reads zero and a same-cycle writeback is bypassed
   assign rn_data = (rn == ZERO_REG) ? '0 :
                    (wb_we_i && wb_addr_i == rn) ? wb_data_i : rf[rn];
   assign rm_data = (rm_sel == ZERO_REG) ? '0 :
                    (wb_we_i && wb_addr_i == rm_sel) ? wb_data_i : rf[rm_sel];

   always_ff @(posedge clk) begin
      if (wb_we_i && wb_addr_i != ZERO_REG) begin
         rf[wb_addr_i] <= wb_data_i;
      end
   end

   // ADDI immediate is unsigned and the D-type offset is signed
   assign imm_d = is_addi ? {{(DATA_W-12){1'b0}}, instr_i[21:10]}
                          : {{(DATA_W-9){instr_i[20]}}, instr_i[20:12]};

   // ID/EX register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         ex_o.valid <= 1'b0;
         ex_o.ctrl  <= '0;
      end else begin
         ex_o.valid <= instr_valid_i;
         ex_o.ctrl  <= ctrl_d;
      end
   end

   always_ff @(posedge clk) begin
      ex_o.op_a     <= rn_data;
      ex_o.op_b_reg <= rm_data;
      ex_o.imm      <= imm_d;
      ex_o.rd       <= instr_i[4:0];
   end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
   input  wire logic clk,
   input  wire logic reset,
   id_ex_if.dst      id_i,
   ex_mem_if.src     mem_o
);
   import arm_pkg::*;

   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] alu_result_d;

   // immediate as second operand for ADDI and loads/stores
   assign op_b = id_i.ctrl.use_imm ? id_i.imm : id_i.op_b_reg;

   always_comb begin
      case (id_i.ctrl.alu_op)
         ALU_ADD: alu_result_d = id_i.op_a + op_b;
         ALU_SUB: alu_result_d = id_i.op_a - op_b;
         ALU_AND: alu_result_d = id_i.op_a & op_b;
         ALU_ORR: alu_result_d = id_i.op_a | op_b;
         default: alu_result_d = '0;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         mem_o.valid <= 1'b0;
         mem_o.ctrl  <= '0;
      end else begin
         mem_o.valid <= id_i.valid;
         mem_o.ctrl  <= id_i.ctrl;
      end
   end

   // store data is the unmuxed register operand
   always_ff @(posedge clk) begin
      mem_o.alu_result <= alu_result_d;
      mem_o.store_data <= id_i.op_b_reg;
      mem_o.rd         <= id_i.rd;
   end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
   parameter int IMEM_AW = arm_pkg::IMEM_AW
) (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic                        host_en_i,
   input  wire logic                        host_we_i,
   input  wire logic [IMEM_AW-1:0]          host_addr_i,
   input  wire logic [arm_pkg::INSTR_W-1:0] host_wdata_i,
   output logic      [arm_pkg::INSTR_W-1:0] host_rdata_o,
   output logic      [arm_pkg::INSTR_W-1:0] instr_o,
   output logic                             instr_valid_o
);
   import arm_pkg::*;

   logic [INSTR_W-1:0] imem [2**IMEM_AW];
   logic [IMEM_AW-1:0] pc;
   logic [IMEM_AW-1:0] imem_addr;
   logic [INSTR_W-1:0] rd_word;

   // host owns the memory port while enabled
   assign imem_addr = host_en_i ? host_addr_i : pc;

   // pc parks at zero under host control and then counts up
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc <= '0;
      end else if (host_en_i) begin
         pc <= '0;
      end else begin
         pc <= pc + 1'b1;
      end
   end

   // host load port
   always_ff @(posedge clk) begin
      if (host_en_i && host_we_i) begin
         imem[host_addr_i] <= host_wdata_i;
      end
   end

   // registered read that doubles as the IF/ID register
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         rd_word       <= '0;
         instr_valid_o <= 1'b0;
      end else begin
         rd_word       <= imem[imem_addr];
         instr_valid_o <= !host_en_i;
      end
   end

   assign instr_o      = rd_word;
   assign host_rdata_o = rd_word;

endmodule

`default_nettype wire

// File: hdl/memory_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
   parameter int DMEM_AW = arm_pkg::DMEM_AW
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic [DMEM_AW-1:0]         dbg_addr_i,
   ex_mem_if.dst                           ex_i,
   output logic      [arm_pkg::DATA_W-1:0] dbg_data_o,
   output logic                            wb_we_o,
   output logic      [arm_pkg::REG_AW-1:0] wb_addr_o,
   output logic      [arm_pkg::DATA_W-1:0] wb_data_o
);
   import arm_pkg::*;

   logic [DATA_W-1:0]  dmem [2**DMEM_AW];
   logic [DMEM_AW-1:0] dw_addr;
   logic [DATA_W-1:0]  ld_data_q;
   logic [DATA_W-1:0]  alu_q;
   logic               mem_to_reg_q;

   // doubleword index from the byte address
   assign dw_addr = ex_i.alu_result[DMEM_AW+2:3];

   always_ff @(posedge clk) begin
      if (ex_i.valid && ex_i.ctrl.mem_write) begin
         dmem[dw_addr] <= ex_i.store_data;
      end
      if (ex_i.valid && ex_i.ctrl.mem_read) begin
         ld_data_q <= dmem[dw_addr];
      end
      alu_q        <= ex_i.alu_result;
      mem_to_reg_q <= ex_i.ctrl.mem_to_reg;
      wb_addr_o    <= ex_i.rd;
   end

   // MEM/WB enable and debug read port
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wb_we_o    <= 1'b0;
         dbg_data_o <= '0;
      end else begin
         wb_we_o    <= ex_i.valid && ex_i.ctrl.reg_write && (ex_i.rd != '1);
         dbg_data_o <= dmem[dbg_addr_i];
      end
   end

   assign wb_data_o = mem_to_reg_q ? ld_data_q : alu_q;

endmodule

`default_nettype wire

// File: hdl/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute payload
interface id_ex_if;
   import arm_pkg::*;

   logic              valid;
   ctrl_t             ctrl;
   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b_reg;
   logic [DATA_W-1:0] imm;
   logic [REG_AW-1:0] rd;

   modport src (output valid, ctrl, op_a, op_b_reg, imm, rd);
   modport dst (input  valid, ctrl, op_a, op_b_reg, imm, rd);
endinterface

// execute to memory payload
interface ex_mem_if;
   import arm_pkg::*;

   logic              valid;
   ctrl_t             ctrl;
   logic [DATA_W-1:0] alu_result;
   logic [DATA_W-1:0] store_data;
   logic [REG_AW-1:0] rd;

   modport src (output valid, ctrl, alu_result, store_data, rd);
   modport dst (input  valid, ctrl, alu_result, store_data, rd);
endinterface

`default_nettype wire

// File: tests/arm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arm_core_tb;

   localparam int IMEM_AW      = 6;
   localparam int DMEM_AW      = 7;
   localparam int IMEM_DEPTH   = 2**IMEM_AW;
   localparam int DMEM_DEPTH   = 2**DMEM_AW;
   localparam int PERIOD_NS    = 100;
   localparam int NUM_TESTS    = 4;
   localparam int NUM_EXP      = 16;
   localparam int RUN_CYCLES   = IMEM_DEPTH + 8;
   localparam int DRAIN_CYCLES = 8;
   // each test walks the memory to load, read back and run, plus margin
   localparam int WATCHDOG_NS  = (4 * IMEM_DEPTH + 40) * PERIOD_NS * (NUM_TESTS + 1);
   localparam logic [31:0] NOP = 32'h0000_0000;

   localparam logic [10:0] OPC_ADD  = 11'b100_0101_1000;
   localparam logic [10:0] OPC_SUB  = 11'b110_0101_1000;
   localparam logic [10:0] OPC_AND  = 11'b100_0101_0000;
   localparam logic [10:0] OPC_ORR  = 11'b101_0101_0000;
   localparam logic [9:0]  OPC_ADDI = 10'b10_0100_0100;
   localparam logic [10:0] OPC_LDUR = 11'b111_1100_0010;
   localparam logic [10:0] OPC_STUR = 11'b111_1100_0000;

   logic                 clk;
   logic                 reset;
   logic                 host_en;
   logic                 host_we;
   logic [IMEM_AW-1:0]   host_addr;
   logic [31:0]          host_wdata;
   logic [31:0]          host_rdata;
   logic [DMEM_AW-1:0]   dbg_addr;
   logic [63:0]          dbg_data;

   logic [31:0] prog [NUM_TESTS][IMEM_DEPTH];
   logic [63:0] model_x [32];
   logic [63:0] model_mem [DMEM_DEPTH];
   integer      seed;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   string test_name [NUM_TESTS] = '{"alu ops", "load after store", "zero register",
                                    "unknown opcode"};

   // expected values are filled in by the model
   int          exp_test [NUM_EXP] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 2, 2, 2, 2, 3, 3, 3};
   int          exp_addr [NUM_EXP] = '{0, 1, 2, 3, 4, 5, 6, 8, 9, 10, 11, 12, 13, 14, 15, 16};
   logic [63:0] exp_val  [NUM_EXP];

   tb_clock #(.PERIOD_NS(PERIOD_NS)) u_clock (.clk_o(clk));

   arm_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_arm_core (
      .clk          (clk),
      .reset        (reset),
      .host_en_i    (host_en),
      .host_we_i    (host_we),
      .host_addr_i  (host_addr),
      .host_wdata_i (host_wdata),
      .host_rdata_o (host_rdata),
      .dbg_addr_i   (dbg_addr),
      .dbg_data_o   (dbg_data)
   );

   function automatic logic [31:0] r_type(input logic [10:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rn, input logic [4:0] rm);
      return {opc, rm, 6'd0, rn, rd};
   endfunction

   function automatic logic [31:0] i_type(input logic [4:0] rd, input logic [4:0] rn,
                                          input logic [11:0] imm);
      return {OPC_ADDI, imm, rn, rd};
   endfunction

   function automatic logic [31:0] d_type(input logic [10:0] opc, input logic [4:0] rt,
                                          input logic [4:0] rn, input logic [8:0] off);
      return {opc, off, 2'b00, rn, rt};
   endfunction

   function automatic logic [11:0] random_imm();
      logic [31:0] r;
      r = $random(seed);
      return r[11:0];
   endfunction

   task automatic build_programs();
      for (int t = 0; t < NUM_TESTS; t++) begin
         for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[t][i] = NOP;
         end
      end
      // every ALU result ends up in dw 0..5
      prog[0][0]  = i_type(1, 31, random_imm());
      prog[0][1]  = i_type(2, 31, random_imm());
      prog[0][2]  = i_type(3, 31, random_imm());
      prog[0][3]  = i_type(5, 1, random_imm());
      prog[0][4]  = r_type(OPC_ADD, 4, 1, 2);
      prog[0][5]  = r_type(OPC_SUB, 6, 1, 3);
      prog[0][6]  = r_type(OPC_AND, 7, 2, 5);
      prog[0][7]  = r_type(OPC_ORR, 8, 3, 4);
      prog[0][8]  = d_type(OPC_STUR, 1, 31, 0);
      prog[0][9]  = d_type(OPC_STUR, 5, 31, 8);
      prog[0][10] = d_type(OPC_STUR, 4, 31, 16);
      prog[0][11] = d_type(OPC_STUR, 6, 31, 24);
      prog[0][12] = d_type(OPC_STUR, 7, 31, 32);
      prog[0][13] = d_type(OPC_STUR, 8, 31, 40);
      // store, reload through a base with negative offset, modify, store again
      prog[1][0]  = i_type(10, 31, random_imm());
      prog[1][1]  = i_type(11, 31, random_imm());
      prog[1][2]  = i_type(12, 31, 64);
      prog[1][3]  = d_type(OPC_STUR, 10, 31, 48);
      prog[1][5]  = d_type(OPC_LDUR, 13, 12, -16);
      prog[1][8]  = r_type(OPC_ADD, 14, 13, 11);
      prog[1][11] = d_type(OPC_STUR, 14, 12, 8);
      prog[1][12] = d_type(OPC_STUR, 13, 12, 0);
      // X31 as target and as source
      prog[2][0]  = i_type(31, 31, random_imm());
      prog[2][1]  = i_type(20, 31, random_imm());
      prog[2][4]  = r_type(OPC_ADD, 21, 31, 20);
      prog[2][5]  = r_type(OPC_ORR, 31, 20, 20);
      prog[2][6]  = r_type(OPC_AND, 22, 20, 31);
      prog[2][8]  = i_type(23, 31, random_imm());
      prog[2][9]  = d_type(OPC_STUR, 31, 31, 80);
      prog[2][10] = d_type(OPC_STUR, 21, 31, 88);
      prog[2][11] = d_type(OPC_STUR, 22, 31, 96);
      prog[2][12] = d_type(OPC_STUR, 23, 31, 104);
      // words 5 and 6 lie outside the subset
      prog[3][0]  = i_type(24, 31, random_imm());
      prog[3][1]  = i_type(25, 31, random_imm());
      prog[3][3]  = d_type(OPC_STUR, 24, 31, 112);
      prog[3][4]  = d_type(OPC_STUR, 25, 31, 120);
      prog[3][5]  = r_type(11'b111_1101_0000, 24, 25, 25);
      prog[3][6]  = d_type(11'b101_1100_0000, 25, 31, 112);
      prog[3][9]  = d_type(OPC_STUR, 24, 31, 128);
   endtask

   function automatic logic [63:0] reg_value(input logic [4:0] r);
      return (r == 5'd31) ? 64'd0 : model_x[r];
   endfunction

   task automatic write_reg(input logic [4:0] r, input logic [63:0] v);
      if (r != 5'd31) begin
         model_x[r] = v;
      end
   endtask

   // sequential reference model running one instruction at a time
   task automatic run_model(input int t);
      logic [31:0] w;
      logic [4:0]  rd;
      logic [4:0]  rn;
      logic [4:0]  rm;
      logic [63:0] addr;
      int          dw;
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         w    = prog[t][i];
         rd   = w[4:0];
         rn   = w[9:5];
         rm   = w[20:16];
         addr = reg_value(rn) + {{55{w[20]}}, w[20:12]};
         dw   = int'((addr >> 3) % DMEM_DEPTH);
         if (w[31:22] == OPC_ADDI) begin
            write_reg(rd, reg_value(rn) + {52'd0, w[21:10]});
         end else begin
            case (w[31:21])
               OPC_ADD:  write_reg(rd, reg_value(rn) + reg_value(rm));
               OPC_SUB:  write_reg(rd, reg_value(rn) - reg_value(rm));
               OPC_AND:  write_reg(rd, reg_value(rn) & reg_value(rm));
               OPC_ORR:  write_reg(rd, reg_value(rn) | reg_value(rm));
               OPC_LDUR: write_reg(rd, model_mem[dw]);
               OPC_STUR: model_mem[dw] = reg_value(rd);
               default: ;
            endcase
         end
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic load_program(input int t);
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         host_we    = 1'b1;
         host_addr  = i[IMEM_AW-1:0];
         host_wdata = prog[t][i];
         @(negedge clk);
      end
      host_we = 1'b0;
   endtask

   task automatic read_back_program(input int t);
      for (int i = 0; i < IMEM_DEPTH; i++) begin
         host_addr = i[IMEM_AW-1:0];
         @(negedge clk);
         check_value($sformatf("host_rdata_o[%0d]", i), host_rdata, prog[t][i]);
      end
   endtask

   // let the program run past one full pass and then drain the pipe
   task automatic run_program();
      host_en = 1'b0;
      repeat (RUN_CYCLES) @(negedge clk);
      host_en = 1'b1;
      repeat (DRAIN_CYCLES) @(negedge clk);
   endtask

   task automatic check_dmem(input int e);
      dbg_addr = exp_addr[e][DMEM_AW-1:0];
      @(negedge clk);
      check_value($sformatf("dbg_data_o[%0d]", exp_addr[e]), dbg_data, exp_val[e]);
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, test_errors);
      end
   endtask

   initial begin
      reset        = 1'b0;
      host_en      = 1'b1;
      host_we      = 1'b0;
      host_addr    = '0;
      host_wdata   = '0;
      dbg_addr     = '0;
      seed         = 32'h837a_2a1f;
      tests_passed = 0;
      tests_failed = 0;
      build_programs();
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_model(t);
         for (int e = 0; e < NUM_EXP; e++) begin
            if (exp_test[e] == t) begin
               exp_val[e] = model_mem[exp_addr[e]];
            end
         end
      end
      repeat (5) @(negedge clk);
      test_errors = 0;
      check_value("host_rdata_o", host_rdata, 64'd0);
      check_value("dbg_data_o", dbg_data, 64'd0);
      reset = 1'b1;
      finish_test("reset");
      for (int t = 0; t < NUM_TESTS; t++) begin
         test_errors = 0;
         load_program(t);
         read_back_program(t);
         run_program();
         for (int e = 0; e < NUM_EXP; e++) begin
            if (exp_test[e] == t) begin
               check_dmem(e);
            end
         end
         finish_test(test_name[t]);
      end
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run timed out");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 100
) (
   output logic clk_o
);
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end
endmodule

`default_nettype wire
